//--- compile.f
verilog/memory_pkg.sv
verilog/d0_scheduler.sv
verilog/d0_arbiter.sv
verilog/cache_reset_block.sv
verilog/l2_update_block.sv
verilog/d1_stage.sv
verilog/l1d_top.sv
sim/l1d_assert.sv
sim/l1d_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module l1d_tb -f compile.f -o l1d_sim &&
./obj_dir/l1d_sim | tee /dev/stderr | grep -q "^Done: no errors$" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }

//--- sim/l1d_assert.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_assert import memory_pkg::*; (
    input logic       clk_i,
    input logic       rst_i,
    input d0_winner_e winner_i,
    input logic       l2c_rdy_i,
    input logic       lsq_rdy_i
);

    // Only one source is acknowledged per cycle
    assert property (@(posedge clk_i) disable iff (rst_i) !(l2c_rdy_i && lsq_rdy_i))
        else $error("refill and LSQ acknowledged in the same cycle");

    // The refill acknowledge belongs to the L2Cache winner
    assert property (@(posedge clk_i) disable iff (rst_i) l2c_rdy_i |-> winner_i == L2Cache)
        else $error("refill acknowledged while another source owns d0");

    // The sweep owns the arrays, nobody else gets an acknowledge
    assert property (@(posedge clk_i) disable iff (rst_i)
                     winner_i == RstBlock |-> !l2c_rdy_i && !lsq_rdy_i)
        else $error("acknowledge given during the reset sweep");

endmodule

// Arbiter acknowledge rules, sampled on the cache clock
bind l1d_top l1d_assert u_l1d_assert (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .winner_i  (winner),
    .l2c_rdy_i (l2c_rdy_o),
    .lsq_rdy_i (lsq_rdy_o)
);

`default_nettype wire

//--- sim/l1d_tb.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_tb;

    // Each vector takes five words in the data file
    localparam int MAX_VEC   = 32;
    localparam int VEC_WORDS = 5;

    logic        clk_i;
    logic        rst_i;
    logic        lsq_valid_i;
    logic        lsq_we_i;
    logic [7:0]  lsq_addr_i;
    logic [31:0] lsq_wdata_i;
    logic        lsq_rdy_o;
    logic        rsp_valid_o;
    logic [31:0] rsp_rdata_o;
    logic        l2_req_o;
    logic [7:0]  l2_req_addr_o;
    logic        l2c_valid_i;
    logic [31:0] l2c_data_i;
    logic        l2c_rdy_o;
    logic        l2_wr_o;
    logic [7:0]  l2_wr_addr_o;
    logic [31:0] l2_wr_data_o;

    logic [31:0] vec_mem [0:MAX_VEC*VEC_WORDS-1];
    logic [31:0] l2_mem [0:255];

    // Shadow of the cache state, updated in the order requests are accepted
    logic [3:0]  sh_tag [0:15];
    logic [31:0] sh_data [0:15];
    logic        sh_valid [0:15];
    logic        sh_dirty [0:15];

    // Accepted requests waiting for their response
    int          rsp_q[$];
    int          acc_cyc_q[$];
    logic        hit_q[$];
    // Refill and writeback traffic the cache is expected to produce
    logic [7:0]  miss_q[$];
    logic [7:0]  wb_addr_q[$];
    logic [31:0] wb_data_q[$];

    int          seed;
    int          n_vec;
    int          vec_idx;
    int          cyc;
    int          limit;
    int          err_count;
    int          test_errs [0:15];
    int          tests_done;
    logic        timed_out;
    logic        finished;

    // L2 model state, one refill at a time
    logic        l2_busy;
    int          l2_delay;
    logic [7:0]  l2_addr;

    l1d_top u_l1d_top (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lsq_valid_i   (lsq_valid_i),
        .lsq_we_i      (lsq_we_i),
        .lsq_addr_i    (lsq_addr_i),
        .lsq_wdata_i   (lsq_wdata_i),
        .lsq_rdy_o     (lsq_rdy_o),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_rdata_o   (rsp_rdata_o),
        .l2_req_o      (l2_req_o),
        .l2_req_addr_o (l2_req_addr_o),
        .l2c_valid_i   (l2c_valid_i),
        .l2c_data_i    (l2c_data_i),
        .l2c_rdy_o     (l2c_rdy_o),
        .l2_wr_o       (l2_wr_o),
        .l2_wr_addr_o  (l2_wr_addr_o),
        .l2_wr_data_o  (l2_wr_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] field(input int v, input int k);
        return vec_mem[v*VEC_WORDS + k];
    endfunction

    // Column 0 is the test number
    function automatic int test_of(input int v);
        return int'(field(v, 0) & 32'h0000_000f);
    endfunction

    task automatic check_value(input int test_id, input string name,
                               input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h (test %0d)",
                     $time, name, got, expected, test_id);
            err_count++;
            test_errs[test_id]++;
        end
    endtask

    task automatic report_failure(input int test_id, input string msg);
        $display("Failure at %0t ns in test %0d: %s", $time, test_id, msg);
        err_count++;
        test_errs[test_id]++;
    endtask

    // Direct-mapped write-back rule applied to one accepted request
    task automatic accept_request(input int v);
        logic [7:0] addr;
        logic [3:0] idx;
        logic [3:0] tag;
        logic       hit;
        addr = 8'(field(v, 2));
        idx  = addr[3:0];
        tag  = addr[7:4];
        hit  = sh_valid[idx] && (sh_tag[idx] == tag);
        if (!hit) begin
            // A dirty victim leaves before the refill is asked for
            if (sh_valid[idx] && sh_dirty[idx]) begin
                wb_addr_q.push_back({sh_tag[idx], idx});
                wb_data_q.push_back(sh_data[idx]);
            end
            miss_q.push_back(addr);
            sh_valid[idx] = 1'b1;
            sh_tag[idx]   = tag;
            sh_dirty[idx] = 1'b0;
            sh_data[idx]  = field(v, 4);
        end
        if (1'(field(v, 1))) begin
            sh_data[idx]  = field(v, 3);
            sh_dirty[idx] = 1'b1;
        end
        rsp_q.push_back(v);
        acc_cyc_q.push_back(cyc);
        hit_q.push_back(hit);
    endtask

    task automatic take_response();
        int   v;
        int   acc;
        logic hit;
        int   t;
        if (rsp_q.size() == 0) begin
            report_failure(0, "response arrived with no request outstanding");
        end else begin
            v   = rsp_q.pop_front();
            acc = acc_cyc_q.pop_front();
            hit = hit_q.pop_front();
            t   = test_of(v);
            check_value(t, "rsp_rdata_o", rsp_rdata_o, field(v, 4));
            // A hit answers two cycles after the accepting cycle
            if (hit) begin
                check_value(t, "hit latency", cyc - acc, 2);
            end
            if (v == n_vec - 1 || test_of(v + 1) != t) begin
                $display("Test %0d finished with %0d errors", t, test_errs[t]);
                tests_done++;
            end
        end
    endtask

    task automatic take_writeback();
        int t;
        t = (rsp_q.size() > 0) ? test_of(rsp_q[0]) : 0;
        if (wb_addr_q.size() == 0) begin
            report_failure(t, "writeback to L2 that no eviction called for");
        end else begin
            check_value(t, "l2_wr_addr_o", {24'b0, l2_wr_addr_o}, {24'b0, wb_addr_q.pop_front()});
            check_value(t, "l2_wr_data_o", l2_wr_data_o, wb_data_q.pop_front());
        end
        l2_mem[l2_wr_addr_o] = l2_wr_data_o;
    endtask

    // L2 keeps the word valid until the cache acknowledges it
    task automatic step_l2();
        int t;
        t = (rsp_q.size() > 0) ? test_of(rsp_q[0]) : 0;
        if (l2_busy) begin
            if (l2c_valid_i && l2c_rdy_o) begin
                l2_busy = 1'b0;
            end else if (!l2c_valid_i && l2_delay > 0) begin
                l2_delay--;
            end
        end else if (l2_req_o) begin
            if (miss_q.size() == 0) begin
                report_failure(t, "refill requested for a request that should hit");
            end else begin
                check_value(t, "l2_req_addr_o", {24'b0, l2_req_addr_o},
                            {24'b0, miss_q.pop_front()});
            end
            if (wb_addr_q.size() != 0) begin
                report_failure(t, "refill requested before the dirty victim was written");
            end
            l2_busy  = 1'b1;
            l2_addr  = l2_req_addr_o;
            l2_delay = 1 + int'($unsigned($random(seed)) % 6);
        end
    endtask

    initial begin
        seed        = 32'h0dafbcd5;
        rst_i       = 1'b1;
        lsq_valid_i = 1'b0;
        lsq_we_i    = 1'b0;
        lsq_addr_i  = 8'h00;
        lsq_wdata_i = 32'h0;
        l2c_valid_i = 1'b0;
        l2c_data_i  = 32'h0;
        err_count   = 0;
        tests_done  = 0;
        timed_out   = 1'b0;
        finished    = 1'b0;
        l2_busy     = 1'b0;
        l2_delay    = 0;
        l2_addr     = 8'h00;
        for (int i = 0; i < 16; i++) begin
            test_errs[i] = 0;
            sh_valid[i]  = 1'b0;
            sh_dirty[i]  = 1'b0;
            sh_tag[i]    = 4'h0;
            sh_data[i]   = 32'h0;
        end
        for (int i = 0; i < 256; i++) begin
            l2_mem[i] = 32'(i) ^ 32'hA5A50000;
        end
        // All ones marks the end of the vectors
        for (int i = 0; i < MAX_VEC*VEC_WORDS; i++) begin
            vec_mem[i] = 32'hffff_ffff;
        end
        $readmemh("sim/l1d_testdata.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && field(n_vec, 0) != 32'hffff_ffff) begin
            n_vec++;
        end
        limit = n_vec * 16 + 64;

        repeat (4) @(negedge clk_i);
        rst_i   = 1'b0;
        vec_idx = 0;
        cyc     = 0;
        while (!finished) begin
            // Drive phase on the falling edge
            if (vec_idx < n_vec) begin
                lsq_valid_i = 1'b1;
                lsq_we_i    = 1'(field(vec_idx, 1));
                lsq_addr_i  = 8'(field(vec_idx, 2));
                lsq_wdata_i = field(vec_idx, 3);
            end else begin
                lsq_valid_i = 1'b0;
                lsq_we_i    = 1'b0;
            end
            if (l2_busy && l2_delay == 0) begin
                l2c_valid_i = 1'b1;
                l2c_data_i  = l2_mem[l2_addr];
            end else begin
                l2c_valid_i = 1'b0;
            end
            #1;
            // Outputs are settled here, ready levels tell what the next edge accepts
            if (cyc == 0) begin
                check_value(0, "rsp_valid_o", {31'b0, rsp_valid_o}, 0);
                check_value(0, "l2_req_o", {31'b0, l2_req_o}, 0);
                check_value(0, "l2_wr_o", {31'b0, l2_wr_o}, 0);
                check_value(0, "l2c_rdy_o", {31'b0, l2c_rdy_o}, 0);
            end
            if (cyc < 16) begin
                check_value(1, "lsq_rdy_o during sweep", {31'b0, lsq_rdy_o}, 0);
            end else if (cyc == 16) begin
                check_value(1, "lsq_rdy_o after sweep", {31'b0, lsq_rdy_o}, 1);
            end
            if (rsp_valid_o) begin
                take_response();
            end
            if (l2_wr_o) begin
                take_writeback();
            end
            step_l2();
            if (lsq_valid_i && lsq_rdy_o) begin
                accept_request(vec_idx);
                vec_idx++;
            end
            cyc++;
            if (vec_idx == n_vec && rsp_q.size() == 0 && !l2_busy) begin
                finished = 1'b1;
            end else if (cyc >= limit) begin
                timed_out = 1'b1;
                finished  = 1'b1;
            end else begin
                @(negedge clk_i);
            end
        end

        // Every predicted miss and eviction must have shown up on the L2 side
        if (!timed_out && (miss_q.size() != 0 || wb_addr_q.size() != 0)) begin
            report_failure(test_of(n_vec - 1),
                           "an expected refill or writeback never reached L2");
        end
        if (timed_out) begin
            $display("Timeout after %0d cycles with %0d of %0d requests answered",
                     cyc, n_vec - rsp_q.size() - (n_vec - vec_idx), n_vec);
        end
        $display("%0d of %0d tests finished, %0d vectors, %0d errors",
                 tests_done, test_of(n_vec - 1), n_vec, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/l1d_testdata.txt
// Columns: test, op (0 load, 1 store), word address, write data, expected read data
// L2 starts with each word equal to its address xor a5a50000
1 0 13 00000000 a5a50013
2 0 25 00000000 a5a50025
2 0 25 00000000 a5a50025
3 1 25 11112222 11112222
3 0 25 00000000 11112222
4 0 35 00000000 a5a50035
4 0 25 00000000 11112222
5 1 47 cafe0001 cafe0001
5 0 47 00000000 cafe0001
5 0 13 00000000 a5a50013
5 1 13 0badf00d 0badf00d
5 0 57 00000000 a5a50057
5 0 47 00000000 cafe0001
5 0 23 00000000 a5a50023
5 0 13 00000000 0badf00d
5 1 9f 12345678 12345678
5 0 9f 00000000 12345678

//--- verilog/cache_reset_block.sv
`timescale 1ns/1ps
`default_nettype none

module cache_reset_block import memory_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_i,
    // Sweep in progress, the block owns d0 while this is high
    output logic               busy_o,
    // Line whose valid and dirty bits are cleared in this cycle
    output logic [INDEX_W-1:0] clr_index_o
);

    logic               busy_q;
    logic [INDEX_W-1:0] cnt_q;

    // One index per cycle, starting at zero once reset is released
    // The last index clears in the cycle where the count reaches N_LINES-1
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == INDEX_W'(N_LINES - 1)) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign busy_o      = busy_q;
    assign clr_index_o = cnt_q;

endmodule

`default_nettype wire

//--- verilog/d0_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module d0_arbiter import memory_pkg::*; (
    // Source picked by the scheduler
    input  d0_winner_e winner_i,
    // d1 is empty or retires its item in this cycle
    input  logic       d1_rdy_i,
    // d1 holds a missed request that waits for its refill
    input  logic       d1_stalled_i,
    // Acknowledge toward L2 for the refill word
    output logic       l2c_rdy_o,
    // Acknowledge toward the LSQ for the request
    output logic       lsq_rdy_o,
    // d0 performs the winner's action and feeds d1 at the next edge
    output logic       d0_enable_o
);

    always_comb begin
        // Nothing is served unless a case below says so
        l2c_rdy_o   = 1'b0;
        lsq_rdy_o   = 1'b0;
        d0_enable_o = 1'b0;
        case (winner_i)
            // The sweep runs before any item can be in d1
            RstBlock: begin
                d0_enable_o = 1'b1;
            end
            // The replay replaces the parked request, so d1 always has room
            D1: begin
                d0_enable_o = 1'b1;
            end
            // A refill only writes the array, so a stalled d1 does not block it
            L2Cache: begin
                if (d1_rdy_i || d1_stalled_i) begin
                    l2c_rdy_o   = 1'b1;
                    d0_enable_o = 1'b1;
                end
            end
            // The victim read carries an item into d1 and needs a free slot
            // It has no acknowledge since d1 itself loaded the update block
            UpdateL2: begin
                if (d1_rdy_i) begin
                    d0_enable_o = 1'b1;
                end
            end
            // New work enters only when d1 makes room
            LSQ: begin
                if (d1_rdy_i) begin
                    lsq_rdy_o   = 1'b1;
                    d0_enable_o = 1'b1;
                end
            end
            default: begin
                d0_enable_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/d0_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module d0_scheduler import memory_pkg::*; (
    // Reset sweep still running
    input  logic       rst_busy_i,
    // d1 asks to replay its held request
    input  logic       d1_replay_i,
    // Refill data waiting from L2
    input  logic       l2c_valid_i,
    // A dirty victim waits to be read out
    input  logic       upd_pending_i,
    // The LSQ presents a request
    input  logic       lsq_valid_i,
    // Source that owns d0 in this cycle
    output d0_winner_e winner_o
);

    // Fixed priority, highest first
    // The sweep must finish before any other access touches the arrays
    // A replay always goes first after a refill so the held request completes
    // A refill is never kept waiting behind new work
    // The victim read comes before new LSQ work so the miss can proceed
    always_comb begin
        if (rst_busy_i) begin
            winner_o = RstBlock;
        end else if (d1_replay_i) begin
            winner_o = D1;
        end else if (l2c_valid_i) begin
            winner_o = L2Cache;
        end else if (upd_pending_i) begin
            winner_o = UpdateL2;
        end else if (lsq_valid_i) begin
            winner_o = LSQ;
        end else begin
            winner_o = NoReq;
        end
    end

endmodule

`default_nettype wire

//--- verilog/d1_stage.sv
`timescale 1ns/1ps
`default_nettype none

module d1_stage import memory_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_i,
    input  d0_winner_e         winner_i,
    input  logic               d0_enable_i,
    input  logic [INDEX_W-1:0] clr_index_i,
    input  logic               lsq_we_i,
    input  logic [ADDR_W-1:0]  lsq_addr_i,
    input  logic [DATA_W-1:0]  lsq_wdata_i,
    input  logic [DATA_W-1:0]  l2c_data_i,
    input  logic [INDEX_W-1:0] upd_index_i,
    output logic               d1_rdy_o,
    output logic               d1_stalled_o,
    output logic               d1_replay_o,
    output logic               dirty_miss_o,
    output logic [INDEX_W-1:0] victim_index_o,
    output logic               rsp_valid_o,
    output logic [DATA_W-1:0]  rsp_rdata_o,
    output logic               l2_req_o,
    output logic [ADDR_W-1:0]  l2_req_addr_o,
    output logic               l2_wr_o,
    output logic [ADDR_W-1:0]  l2_wr_addr_o,
    output logic [DATA_W-1:0]  l2_wr_data_o
);

    // Cache arrays, valid and dirty start undefined until the sweep
    logic [TAG_W-1:0]   tag_mem [N_LINES];
    logic [DATA_W-1:0]  data_mem [N_LINES];
    logic [N_LINES-1:0] valid_mem;
    logic [N_LINES-1:0] dirty_mem;

    // d1 control, the request fields stay put through the whole miss
    logic d1_valid_q, d1_upd_q, stalled_q, replay_q, rsp_valid_q;
    logic               req_we_q;
    logic [ADDR_W-1:0]  req_addr_q;
    logic [DATA_W-1:0]  req_wdata_q;
    // Line contents read in d0 for the item now in d1
    logic [INDEX_W-1:0] rd_idx_q;
    logic [TAG_W-1:0]   rd_tag_q;
    logic [DATA_W-1:0]  rd_data_q, rsp_rdata_q;
    logic               rd_valid_q, rd_dirty_q;

    logic               do_clr, cap_fill, cap_lsq, cap_rep, cap_upd, cap_any;
    logic [INDEX_W-1:0] req_idx, rd_idx;
    logic [TAG_W-1:0]   req_tag;
    logic               req_chk, upd_chk, hit, miss, st_hit, fwd;

    // Action taken by d0 in this cycle
    assign do_clr   = d0_enable_i && (winner_i == RstBlock);
    assign cap_fill = d0_enable_i && (winner_i == L2Cache);
    assign cap_rep  = d0_enable_i && (winner_i == D1);
    assign cap_lsq  = d0_enable_i && (winner_i == LSQ);
    assign cap_upd  = d0_enable_i && (winner_i == UpdateL2);
    assign cap_any  = cap_lsq || cap_rep || cap_upd;

    assign req_idx = req_addr_q[INDEX_W-1:0];
    assign req_tag = req_addr_q[ADDR_W-1:INDEX_W];

    // A replay reads the held request again, the victim read uses the pending index
    always_comb begin
        if (winner_i == LSQ) begin
            rd_idx = lsq_addr_i[INDEX_W-1:0];
        end else if (winner_i == D1) begin
            rd_idx = req_idx;
        end else begin
            rd_idx = upd_index_i;
        end
    end

    // Tag check on the item registered at the last edge
    assign req_chk = d1_valid_q && !d1_upd_q;
    assign upd_chk = d1_valid_q && d1_upd_q;
    assign hit     = rd_valid_q && (rd_tag_q == req_tag);
    assign miss    = req_chk && !hit;
    assign st_hit  = req_chk && hit && req_we_q;
    // A store retiring now would be missed by the d0 read of the same line
    assign fwd     = st_hit && (rd_idx == req_idx);

    always_ff @(posedge clk_i) begin
        if (do_clr) begin
            valid_mem[clr_index_i] <= 1'b0;
            dirty_mem[clr_index_i] <= 1'b0;
        end
        // Refill installs the missed line clean, a replay then finds it
        if (cap_fill) begin
            tag_mem[req_idx]   <= req_tag;
            data_mem[req_idx]  <= l2c_data_i;
            valid_mem[req_idx] <= 1'b1;
            dirty_mem[req_idx] <= 1'b0;
        end
        if (st_hit) begin
            data_mem[req_idx]  <= req_wdata_q;
            dirty_mem[req_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            d1_valid_q  <= 1'b0;
            d1_upd_q    <= 1'b0;
            stalled_q   <= 1'b0;
            replay_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            d1_valid_q  <= cap_any;
            d1_upd_q    <= cap_upd;
            rsp_valid_q <= req_chk && hit;
            // A dirty miss waits for its victim to leave before asking L2
            if ((miss && !rd_dirty_q) || upd_chk) begin
                stalled_q <= 1'b1;
            end else if (cap_fill) begin
                stalled_q <= 1'b0;
            end
            replay_q <= cap_fill;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cap_lsq) begin
            req_we_q    <= lsq_we_i;
            req_addr_q  <= lsq_addr_i;
            req_wdata_q <= lsq_wdata_i;
        end
        if (cap_any) begin
            rd_idx_q   <= rd_idx;
            rd_tag_q   <= tag_mem[rd_idx];
            rd_valid_q <= valid_mem[rd_idx];
            rd_data_q  <= fwd ? req_wdata_q : data_mem[rd_idx];
            rd_dirty_q <= fwd || dirty_mem[rd_idx];
        end
        // Stores echo their data, loads return the line
        rsp_rdata_q <= req_we_q ? req_wdata_q : rd_data_q;
    end

    // The victim drain slot is the only use of d1 while the update block is pending
    assign d1_rdy_o       = (!d1_valid_q && !stalled_q && !replay_q) || (req_chk && hit);
    assign d1_stalled_o   = stalled_q;
    assign d1_replay_o    = replay_q;
    assign dirty_miss_o   = miss && rd_valid_q && rd_dirty_q;
    assign victim_index_o = rd_idx_q;
    assign rsp_valid_o    = rsp_valid_q;
    assign rsp_rdata_o    = rsp_rdata_q;
    assign l2_req_o       = stalled_q;
    assign l2_req_addr_o  = req_addr_q;
    assign l2_wr_o        = upd_chk;
    assign l2_wr_addr_o   = {rd_tag_q, rd_idx_q};
    assign l2_wr_data_o   = rd_data_q;

endmodule

`default_nettype wire

//--- verilog/l1d_top.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_top import memory_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    // Load/store queue side
    input  logic              lsq_valid_i,
    input  logic              lsq_we_i,
    input  logic [ADDR_W-1:0] lsq_addr_i,
    input  logic [DATA_W-1:0] lsq_wdata_i,
    output logic              lsq_rdy_o,
    output logic              rsp_valid_o,
    output logic [DATA_W-1:0] rsp_rdata_o,
    // Refill from L2
    output logic              l2_req_o,
    output logic [ADDR_W-1:0] l2_req_addr_o,
    input  logic              l2c_valid_i,
    input  logic [DATA_W-1:0] l2c_data_i,
    output logic              l2c_rdy_o,
    // Writeback toward L2
    output logic              l2_wr_o,
    output logic [ADDR_W-1:0] l2_wr_addr_o,
    output logic [DATA_W-1:0] l2_wr_data_o
);

    d0_winner_e         winner;
    logic               rst_busy, d1_rdy, d1_stalled, d1_replay, d0_enable;
    logic               upd_pending, upd_served, dirty_miss;
    logic [INDEX_W-1:0] clr_index, upd_index, victim_index;

    // The update block releases its entry once d0 reads the victim
    assign upd_served = d0_enable && (winner == UpdateL2);

    d0_scheduler u_d0_scheduler (
        .rst_busy_i    (rst_busy),
        .d1_replay_i   (d1_replay),
        .l2c_valid_i   (l2c_valid_i),
        .upd_pending_i (upd_pending),
        .lsq_valid_i   (lsq_valid_i),
        .winner_o      (winner)
    );

    d0_arbiter u_d0_arbiter (
        .winner_i     (winner),
        .d1_rdy_i     (d1_rdy),
        .d1_stalled_i (d1_stalled),
        .l2c_rdy_o    (l2c_rdy_o),
        .lsq_rdy_o    (lsq_rdy_o),
        .d0_enable_o  (d0_enable)
    );

    cache_reset_block u_cache_reset_block (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .busy_o      (rst_busy),
        .clr_index_o (clr_index)
    );

    l2_update_block u_l2_update_block (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .load_i         (dirty_miss),
        .victim_index_i (victim_index),
        .served_i       (upd_served),
        .pending_o      (upd_pending),
        .index_o        (upd_index)
    );

    d1_stage u_d1_stage (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .winner_i       (winner),
        .d0_enable_i    (d0_enable),
        .clr_index_i    (clr_index),
        .lsq_we_i       (lsq_we_i),
        .lsq_addr_i     (lsq_addr_i),
        .lsq_wdata_i    (lsq_wdata_i),
        .l2c_data_i     (l2c_data_i),
        .upd_index_i    (upd_index),
        .d1_rdy_o       (d1_rdy),
        .d1_stalled_o   (d1_stalled),
        .d1_replay_o    (d1_replay),
        .dirty_miss_o   (dirty_miss),
        .victim_index_o (victim_index),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .l2_req_o       (l2_req_o),
        .l2_req_addr_o  (l2_req_addr_o),
        .l2_wr_o        (l2_wr_o),
        .l2_wr_addr_o   (l2_wr_addr_o),
        .l2_wr_data_o   (l2_wr_data_o)
    );

endmodule

`default_nettype wire

//--- verilog/l2_update_block.sv
`timescale 1ns/1ps
`default_nettype none

module l2_update_block import memory_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_i,
    // d1 found a dirty victim in this cycle
    input  logic               load_i,
    // Index of that victim line
    input  logic [INDEX_W-1:0] victim_index_i,
    // d0 grants the victim read in this cycle
    input  logic               served_i,
    // A victim waits for its d0 slot
    output logic               pending_o,
    // Line that d0 must read out toward L2
    output logic [INDEX_W-1:0] index_o
);

    logic               pending_q;
    logic [INDEX_W-1:0] index_q;

    // Only one miss is outstanding, so one entry is enough
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
        end else if (load_i) begin
            pending_q <= 1'b1;
        end else if (served_i) begin
            pending_q <= 1'b0;
        end
    end

    // Victim index captured together with the dirty miss
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            index_q <= victim_index_i;
        end
    end

    assign pending_o = pending_q;
    assign index_o   = index_q;

endmodule

`default_nettype wire

//--- verilog/memory_pkg.sv
`default_nettype none

package memory_pkg;

    // Geometry of the level-1 data cache
    // Direct-mapped, one 32-bit word per line, write-back with write-allocate

    // Number of index bits, giving the line count below
    localparam int INDEX_W = 4;

    // Tag bits kept per line
    localparam int TAG_W = 4;

    // Word address as seen by the LSQ and by L2, tag on top of index
    localparam int ADDR_W = TAG_W + INDEX_W;

    // Width of one cache word
    localparam int DATA_W = 32;

    // Lines in the array, one per index value
    localparam int N_LINES = 1 << INDEX_W;

    // Source served by stage d0 in a given cycle
    // The scheduler ranks them in the order listed here
    // NoReq is the idle value when nobody asks for the array ports
    typedef enum logic [2:0] {
        // Sweep that clears valid and dirty bits after reset
        RstBlock,
        // Replay of the request held in d1 after its refill
        D1,
        // Refill word coming back from L2
        L2Cache,
        // Read of a dirty victim on its way to L2
        UpdateL2,
        // New load or store from the load/store queue
        LSQ,
        // Nothing to do this cycle
        NoReq
    } d0_winner_e;

endpackage

`default_nettype wire
